//--- prefetch_unit.f
+incdir+src
src/prefetch_pkg.sv
src/prefetch_if.sv
src/prefetch_address.sv
src/prefetch_control.sv
src/code_tlb.sv
src/code_reader.sv
src/prefetch_fifo.sv
src/prefetch_unit.sv
tests/prefetch_unit_tb.sv

//--- Makefile
TOP := prefetch_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f prefetch_unit.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing -f prefetch_unit.f --top-module prefetch_unit

clean:
	rm -rf obj_dir

//--- tests/prefetch_golden.txt
// Word 0 is the test count, then 14 hex words per test: writes, 2 x (tlb index,
// linear page, physical page, flags v/u/cd in bits 0/1/2), address, limit, su, bytes, fault
9
// Unaligned start inside one page
1 0 00010 00345 3 0 0 0 0 00010123 ffffffff 0 28 0
// Page cross into an unrelated supervisor page, cache disabled
1 1 00011 07a21 5 0 0 0 0 00010fe6 ffffffff 0 30 0
// Stop at the segment limit in user mode
1 2 00020 00c04 3 0 0 0 0 00020402 00020431 1 30 0
// Stream left running, then a branch elsewhere
0 0 0 0 0 0 0 0 0 00010800 ffffffff 0 0c 0
0 0 0 0 0 0 0 0 0 00020401 00020fff 0 14 0
// TLB miss, then a user fetch from a supervisor page
0 0 0 0 0 0 0 0 0 00033000 ffffffff 0 0 1
0 0 0 0 0 0 0 0 0 00011010 ffffffff 1 0 1
// Branch to a valid page clears the fault
0 0 0 0 0 0 0 0 0 00010000 ffffffff 1 10 0
// Two new pages, crossing and ending at the limit
2 3 00040 12345 3 4 00041 0abcd 3 00040fc3 00041022 0 60 0

//--- tests/prefetch_unit_tb.sv
`timescale 1ns/1ps

module prefetch_unit_tb;

    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int WORDS_PER_TEST = 14;
    localparam int SILENCE_CYCLES = 40;

    logic                     clk;
    logic                     arst_n;
    logic                     branch;
    logic [31:0]              branch_address;
    logic [31:0]              cs_limit;
    logic                     su;
    logic                     tlb_write;
    logic [2:0]               tlb_write_index;
    prefetch_pkg::tlb_entry_t tlb_write_entry;
    logic                     mem_req;
    logic [31:0]              mem_address;
    logic                     mem_cache_disable;
    logic                     mem_ack;
    logic [31:0]              mem_rdata;
    logic                     fetch_valid;
    logic [31:0]              fetch_data;
    logic [2:0]               fetch_count;
    logic                     fetch_pop;
    logic                     code_fault;

    // Golden image and reference copy of the TLB
    logic [31:0] golden [0:255];
    logic        ref_valid [8];
    logic [19:0] ref_linear [8];
    logic [19:0] ref_physical [8];
    logic        ref_cd [8];

    logic [31:0] lfsr;
    // 0 ignore output, 1 collect, 2 expect none
    int          mode;
    logic [31:0] exp_address;
    logic [31:0] exp_limit;
    int          collected;
    logic        first_entry;
    int          test_errors;
    logic        mem_waiting;
    int          mem_delay;
    int          watchdog_cycles;
    logic        budget_ready = 1'b0;

    prefetch_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reference helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    // One LFSR step per bit
    task automatic draw_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Memory content rule
    function automatic logic [7:0] memory_byte(input logic [31:0] p);
        return p[7:0] ^ p[15:8] ^ p[23:16];
    endfunction

    function automatic logic [31:0] translate(input logic [31:0] linear);
        logic [31:0] physical;
        int          i;
        physical = 32'hffff_ffff;
        for (i = 0; i < 8; i++) begin
            if (ref_valid[i] && ref_linear[i] == linear[31:12]) begin
                physical = {ref_physical[i], linear[11:0]};
            end
        end
        return physical;
    endfunction

    // ------------------------------------------------------------------
    // Memory model and consumer, once per falling edge
    // ------------------------------------------------------------------
    task automatic model_memory();
        logic [31:0] word;
        logic        mapped;
        logic        cd;
        int          i;
        if (mem_ack) begin
            // Taken at the last rising edge
            mem_ack = 1'b0;
        end else if (!mem_req) begin
            mem_waiting = 1'b0;
        end else begin
            if (!mem_waiting) begin
                draw_bits(2, mem_delay);
                mem_waiting = 1'b1;
            end
            if (mem_delay != 0) begin
                mem_delay--;
            end else begin
                mapped = 1'b0;
                cd     = 1'b0;
                for (i = 0; i < 8; i++) begin
                    if (ref_valid[i] && ref_physical[i] == mem_address[31:12]) begin
                        mapped = 1'b1;
                        cd     = ref_cd[i];
                    end
                end
                if (!mapped) begin
                    $display("Memory read at %h falls outside the mapped pages", mem_address);
                    test_errors++;
                end else if (mem_cache_disable != cd) begin
                    $display("mismatch mem_cache_disable: got %h expected %h",
                             mem_cache_disable, cd);
                    test_errors++;
                end
                for (i = 0; i < 4; i++) begin
                    word[8*i +: 8] = memory_byte({mem_address[31:2], 2'b00} + 32'(i));
                end
                mem_rdata   = word;
                mem_ack     = 1'b1;
                mem_waiting = 1'b0;
            end
        end
    endtask

    task automatic consume_output();
        int          pop;
        int          i;
        logic [7:0]  expected;
        logic [2:0]  first_count;
        logic [32:0] to_limit;
        fetch_pop = 1'b0;
        if (fetch_valid && mode == 2) begin
            $display("Output word %h appeared where no bytes were expected", fetch_data);
            test_errors++;
        end else if (fetch_valid && mode == 1) begin
            // Random back-pressure
            draw_bits(1, pop);
            if (pop != 0) begin
                if (fetch_count == 3'd0 || fetch_count > 3'd4) begin
                    $display("Entry count %0d is out of range", fetch_count);
                    test_errors++;
                end
                if (first_entry) begin
                    // Up to the word end, clipped by the limit
                    to_limit    = {1'b0, exp_limit} - {1'b0, exp_address} + 33'd1;
                    first_count = 3'd4 - {1'b0, exp_address[1:0]};
                    if (to_limit < 33'(first_count)) begin
                        first_count = to_limit[2:0];
                    end
                    if (fetch_count != first_count) begin
                        $display("mismatch fetch_count: got %h expected %h",
                                 fetch_count, first_count);
                        test_errors++;
                    end
                    first_entry = 1'b0;
                end
                for (i = 0; i < 4; i++) begin
                    if (i < int'(fetch_count)) begin
                        expected = memory_byte(translate(exp_address));
                        if (exp_address > exp_limit) begin
                            $display("Byte at %h delivered past the limit %h",
                                     exp_address, exp_limit);
                            test_errors++;
                        end
                        if (fetch_data[8*i +: 8] != expected) begin
                            $display("mismatch fetch_data byte %0d at %h: got %h expected %h",
                                     i, exp_address, fetch_data[8*i +: 8], expected);
                            test_errors++;
                        end
                        exp_address++;
                        collected++;
                    end
                end
                fetch_pop = 1'b1;
            end
        end
    endtask

    task automatic tick();
        @(negedge clk);
        branch    = 1'b0;
        tlb_write = 1'b0;
        model_memory();
        consume_output();
    endtask

    // ------------------------------------------------------------------
    // Golden file replay
    // ------------------------------------------------------------------
    initial begin
        int          tests;
        int          t;
        int          slot;
        int          base;
        int          writes;
        int          bytes;
        int          failed_tests;
        int          total_errors;
        int          total_bytes;
        logic [31:0] start;
        logic [31:0] limit;
        logic [31:0] flags;
        logic [2:0]  index;
        logic        user_mode;
        logic        fault;
        arst_n          = 1'b0;
        branch          = 1'b0;
        branch_address  = '0;
        cs_limit        = '0;
        su              = 1'b0;
        tlb_write       = 1'b0;
        tlb_write_index = '0;
        tlb_write_entry = '0;
        mem_ack         = 1'b0;
        mem_rdata       = '0;
        fetch_pop       = 1'b0;
        lfsr            = 32'h8f2616ed;
        mode            = 0;
        mem_waiting     = 1'b0;
        mem_delay       = 0;
        failed_tests    = 0;
        total_errors    = 0;
        total_bytes     = 0;
        for (t = 0; t < 8; t++) begin
            ref_valid[t] = 1'b0;
        end
        $readmemh("tests/prefetch_golden.txt", golden);
        tests = int'(golden[0]);
        for (t = 0; t < tests; t++) begin
            total_bytes += int'(golden[1 + t * WORDS_PER_TEST + 12]);
        end
        watchdog_cycles = 400 * total_bytes + 100 * tests;
        budget_ready    = 1'b1;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        for (t = 0; t < tests; t++) begin
            base        = 1 + t * WORDS_PER_TEST;
            writes      = int'(golden[base]);
            start       = golden[base + 9];
            limit       = golden[base + 10];
            user_mode   = golden[base + 11][0];
            bytes       = int'(golden[base + 12]);
            fault       = golden[base + 13][0];
            test_errors = 0;
            mode        = 0;
            for (slot = 0; slot < writes; slot++) begin
                tick();
                index = golden[base + 1 + slot * 4][2:0];
                flags = golden[base + 4 + slot * 4];
                tlb_write                     = 1'b1;
                tlb_write_index               = index;
                tlb_write_entry.valid         = flags[0];
                tlb_write_entry.linear_page   = golden[base + 2 + slot * 4][19:0];
                tlb_write_entry.physical_page = golden[base + 3 + slot * 4][19:0];
                tlb_write_entry.user          = flags[1];
                tlb_write_entry.cache_disable = flags[2];
                ref_valid[index]    = flags[0];
                ref_linear[index]   = golden[base + 2 + slot * 4][19:0];
                ref_physical[index] = golden[base + 3 + slot * 4][19:0];
                ref_cd[index]       = flags[2];
            end
            tick();
            branch         = 1'b1;
            branch_address = start;
            cs_limit       = limit;
            su             = user_mode;
            fetch_pop      = 1'b0;
            exp_address    = start;
            exp_limit      = limit;
            collected      = 0;
            first_entry    = 1'b1;
            mode           = fault ? 2 : 1;
            tick();
            // Fault from an earlier test cleared by the branch
            if (code_fault !== 1'b0) begin
                $display("mismatch code_fault: got %h expected %h", code_fault, 1'b0);
                test_errors++;
            end
            if (fault) begin
                while (code_fault !== 1'b1) begin
                    tick();
                end
                repeat (SILENCE_CYCLES) tick();
                if (code_fault !== 1'b1) begin
                    $display("mismatch code_fault: got %h expected %h", code_fault, 1'b1);
                    test_errors++;
                end
            end else begin
                while (collected < bytes && code_fault !== 1'b1) begin
                    tick();
                end
                if (code_fault === 1'b1) begin
                    $display("Code fault raised on a mapped and allowed page");
                    test_errors++;
                end
                // Ends at the limit, nothing more may follow
                if (start + 32'(bytes) - 32'd1 == limit) begin
                    mode = 2;
                    repeat (SILENCE_CYCLES) tick();
                end
            end
            mode = 0;
            if (test_errors == 0) begin
                $display("test %0d passed, %0d bytes from %h", t, collected, start);
            end else begin
                $display("test %0d failed with %0d errors", t, test_errors);
                failed_tests++;
            end
            total_errors += test_errors;
        end

        $display("%0d of %0d tests failed, %0d errors", failed_tests, tests, total_errors);
        if (failed_tests == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Budget scales with the bytes in the golden file
    initial begin
        wait (budget_ready);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles with the DUT still short of bytes", watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- src/prefetch_unit.sv
`timescale 1ns/1ps

module prefetch_unit (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     branch,
    input  logic [31:0]              branch_address,
    input  logic [31:0]              cs_limit,
    input  logic                     su,
    input  logic                     tlb_write,
    input  logic [2:0]               tlb_write_index,
    input  prefetch_pkg::tlb_entry_t tlb_write_entry,
    output logic                     mem_req,
    output logic [31:0]              mem_address,
    output logic                     mem_cache_disable,
    input  logic                     mem_ack,
    input  logic [31:0]              mem_rdata,
    output logic                     fetch_valid,
    output logic [31:0]              fetch_data,
    output logic [2:0]               fetch_count,
    input  logic                     fetch_pop,
    output logic                     code_fault
);

    tlb_code_if    tlb_bus ();
    icache_read_if icache_bus ();

    logic [31:0]              fetch_address;
    logic [5:0]               fetch_length;
    logic                     fetch_su;
    logic                     advance;
    logic [2:0]               advance_count;
    logic                     push;
    prefetch_pkg::code_word_t push_word;
    logic [4:0]               used;

    // ------------------------------------------------------------------
    // Branch loads the address and flushes everything else
    // ------------------------------------------------------------------
    prefetch_address address_i (
        .clk, .arst_n, .branch, .branch_address, .cs_limit, .su,
        .advance, .advance_count, .fetch_address, .fetch_length, .fetch_su
    );

    prefetch_control control_i (
        .clk, .arst_n, .branch, .fetch_address, .fetch_length, .fetch_su, .used,
        .tlb (tlb_bus.requester), .icache (icache_bus.control)
    );

    code_tlb tlb_i (
        .clk, .arst_n, .branch, .tlb_write, .tlb_write_index, .tlb_write_entry,
        .tlb (tlb_bus.translator), .code_fault
    );

    code_reader reader_i (
        .clk, .arst_n, .branch, .icache (icache_bus.reader),
        .mem_req, .mem_address, .mem_cache_disable, .mem_ack, .mem_rdata,
        .push, .push_word, .advance, .advance_count
    );

    prefetch_fifo fifo_i (
        .clk, .arst_n, .branch, .push, .push_word, .fetch_pop,
        .fetch_valid, .fetch_data, .fetch_count, .used
    );

endmodule

//--- src/prefetch_fifo.sv
`timescale 1ns/1ps
`include "prefetch_defines.svh"

module prefetch_fifo (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     branch,
    input  logic                     push,
    input  prefetch_pkg::code_word_t push_word,
    input  logic                     fetch_pop,
    output logic                     fetch_valid,
    output logic [31:0]              fetch_data,
    output logic [2:0]               fetch_count,
    output logic [4:0]               used
);

    localparam int PTR_W = $clog2(`PF_FIFO_DEPTH);

    prefetch_pkg::code_word_t mem [`PF_FIFO_DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    prefetch_pkg::code_word_t head;

    assign head        = mem[rd_ptr];
    // Old contents hidden in the flush cycle
    assign fetch_valid = used != 5'd0 && !branch;
    assign fetch_data  = head.data;
    assign fetch_count = head.count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else if (branch) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fetch_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !fetch_pop) begin
                used <= used + 5'd1;
            end else if (!push && fetch_pop) begin
                used <= used - 5'd1;
            end
        end
    end

    // Stop threshold leaves room for words in flight
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> used != 5'(`PF_FIFO_DEPTH));

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        fetch_pop |-> used != 5'd0);

endmodule

//--- src/code_reader.sv
`timescale 1ns/1ps

module code_reader (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     branch,
    icache_read_if.reader            icache,
    output logic                     mem_req,
    output logic [31:0]              mem_address,
    output logic                     mem_cache_disable,
    input  logic                     mem_ack,
    input  logic [31:0]              mem_rdata,
    output logic                     push,
    output prefetch_pkg::code_word_t push_word,
    output logic                     advance,
    output logic [2:0]               advance_count
);

    prefetch_pkg::reader_state_t state;
    // Latched read, stepped per word
    logic [31:0] address;
    logic [5:0]  left;
    logic        cache_disable;

    logic [2:0]  in_word;
    logic [2:0]  count;
    logic        take;

    // ------------------------------------------------------------------
    // Word trim
    // ------------------------------------------------------------------
    assign in_word = 3'd4 - {1'b0, address[1:0]};
    assign count   = (left < {3'd0, in_word}) ? left[2:0] : in_word;
    // Ack during a branch is thrown away
    assign take    = state == prefetch_pkg::READ && mem_ack && !branch;

    assign mem_req           = state == prefetch_pkg::READ;
    assign mem_address       = {address[31:2], 2'b00};
    assign mem_cache_disable = cache_disable;

    // Drop leading bytes of an unaligned word
    assign push_word.data  = mem_rdata >> {address[1:0], 3'b000};
    assign push_word.count = count;
    assign push            = take;
    assign advance         = take;
    assign advance_count   = count;

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= prefetch_pkg::IDLE;
        end else if (branch) begin
            state <= prefetch_pkg::IDLE;
        end else begin
            case (state)
                prefetch_pkg::IDLE:
                    if (icache.read_do && icache.read_length != 6'd0) begin
                        state <= prefetch_pkg::READ;
                    end
                prefetch_pkg::READ:
                    if (mem_ack && left == {3'd0, count}) begin
                        state <= prefetch_pkg::SETTLE;
                    end
                // Control sees the stepped address before next accept
                default:
                    state <= prefetch_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == prefetch_pkg::IDLE) begin
            address       <= icache.read_address;
            left          <= icache.read_length;
            cache_disable <= icache.read_cache_disable;
        end else if (take) begin
            address <= address + 32'(count);
            left    <= left - {3'd0, count};
        end
    end

endmodule

//--- src/code_tlb.sv
`timescale 1ns/1ps
`include "prefetch_defines.svh"

module code_tlb (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    branch,
    input  logic                    tlb_write,
    input  logic [2:0]              tlb_write_index,
    input  prefetch_pkg::tlb_entry_t tlb_write_entry,
    tlb_code_if.translator          tlb,
    output logic                    code_fault
);

    prefetch_pkg::tlb_entry_t table_q [`PF_TLB_ENTRIES];
    logic [`PF_TLB_ENTRIES-1:0] match;
    prefetch_pkg::tlb_entry_t   hit_entry;
    logic                       hit;
    logic                       allowed;

    // Compare the linear page against every entry
    always_comb begin
        hit_entry = '0;
        for (int i = 0; i < `PF_TLB_ENTRIES; i++) begin
            match[i] = table_q[i].valid &&
                       table_q[i].linear_page == tlb.request_address[31:12];
            if (match[i]) begin
                hit_entry = table_q[i];
            end
        end
    end

    assign hit     = |match;
    // User fetch needs a user page
    assign allowed = !tlb.request_su || hit_entry.user;

    // Entry table, written from outside
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PF_TLB_ENTRIES; i++) begin
                table_q[i] <= '0;
            end
        end else if (tlb_write) begin
            table_q[tlb_write_index] <= tlb_write_entry;
        end
    end

    // One answer per request, fault sticky until the next branch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tlb.resp_do <= 1'b0;
            code_fault  <= 1'b0;
        end else begin
            tlb.resp_do <= tlb.request_do && !tlb.resp_do && !branch && hit && allowed;
            if (branch) begin
                code_fault <= 1'b0;
            end else if (tlb.request_do && !(hit && allowed)) begin
                code_fault <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb.request_do) begin
            tlb.resp_linear        <= tlb.request_address;
            tlb.resp_physical      <= {hit_entry.physical_page, tlb.request_address[11:0]};
            tlb.resp_cache_disable <= hit_entry.cache_disable;
        end
    end

    a_one_match: assert property (@(posedge clk) disable iff (!arst_n)
        tlb.request_do |-> $onehot0(match));

endmodule

//--- src/prefetch_control.sv
`timescale 1ns/1ps
`include "prefetch_defines.svh"

module prefetch_control (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           branch,
    input  logic [31:0]    fetch_address,
    input  logic [5:0]     fetch_length,
    input  logic           fetch_su,
    input  logic [4:0]     used,
    tlb_code_if.requester  tlb,
    icache_read_if.control icache
);

    prefetch_pkg::pf_state_t state;
    // Saved translation
    logic [31:0] linear;
    logic [31:0] physical;
    logic        cache_disable;

    logic [12:0] left_in_page;
    logic [5:0]  length;
    logic        page_cross;
    logic        offset_update;
    logic        can_request;
    logic        take_resp;
    logic        leave_icache;

    // ------------------------------------------------------------------
    // Page clip and translation checks
    // ------------------------------------------------------------------
    assign tlb.request_address = fetch_address;
    assign tlb.request_su      = fetch_su;

    assign left_in_page = 13'd4096 - {1'b0, fetch_address[11:0]};
    assign length = (left_in_page < {7'd0, fetch_length}) ? left_in_page[5:0] : fetch_length;

    assign page_cross    = fetch_address[31:12] != linear[31:12];
    // Same page, reader moved the offset
    assign offset_update = !page_cross && fetch_address[11:0] != linear[11:0];

    assign can_request  = !branch && fetch_length != 6'd0 && used < 5'(`PF_START_USED);
    // Drop an answer for a page the address has since left
    assign take_resp    = can_request && tlb.resp_do &&
                          tlb.resp_linear[31:12] == fetch_address[31:12];
    assign leave_icache = page_cross || branch || used >= 5'(`PF_STOP_USED);

    // ------------------------------------------------------------------
    // Request outputs
    // ------------------------------------------------------------------
    always_comb begin
        tlb.request_do            = 1'b0;
        icache.read_do            = 1'b0;
        // Saved offset is current again by the time the reader leaves SETTLE
        icache.read_address       = physical;
        icache.read_length        = length;
        icache.read_cache_disable = cache_disable;
        if (state == prefetch_pkg::TLB_REQUEST) begin
            // Held high until the answer is sampled
            tlb.request_do = can_request;
            if (take_resp) begin
                icache.read_do            = 1'b1;
                icache.read_address       = {tlb.resp_physical[31:12], fetch_address[11:0]};
                icache.read_cache_disable = tlb.resp_cache_disable;
            end
        end else begin
            // Nothing to ask for at the segment limit
            icache.read_do = !leave_icache && length != 6'd0;
        end
    end

    // ------------------------------------------------------------------
    // State and saved translation
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= prefetch_pkg::TLB_REQUEST;
            linear        <= '0;
            physical      <= '0;
            cache_disable <= 1'b0;
        end else if (state == prefetch_pkg::TLB_REQUEST) begin
            if (take_resp) begin
                linear        <= fetch_address;
                physical      <= {tlb.resp_physical[31:12], fetch_address[11:0]};
                cache_disable <= tlb.resp_cache_disable;
                state         <= prefetch_pkg::ICACHE;
            end
        end else begin
            if (leave_icache) begin
                state <= prefetch_pkg::TLB_REQUEST;
            end
            // Follow the reader inside the page
            if (offset_update) begin
                linear[11:0]   <= fetch_address[11:0];
                physical[11:0] <= fetch_address[11:0];
            end
        end
    end

    // Read only on an answer to a request held the cycle before
    a_read_after_resp: assert property (@(posedge clk) disable iff (!arst_n)
        state == prefetch_pkg::TLB_REQUEST && icache.read_do |-> $past(tlb.request_do));

    a_read_length: assert property (@(posedge clk) disable iff (!arst_n)
        icache.read_do |-> icache.read_length != 6'd0);

endmodule

//--- src/prefetch_address.sv
`timescale 1ns/1ps
`include "prefetch_defines.svh"

module prefetch_address (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        branch,
    input  logic [31:0] branch_address,
    input  logic [31:0] cs_limit,
    input  logic        su,
    input  logic        advance,
    input  logic [2:0]  advance_count,
    output logic [31:0] fetch_address,
    output logic [5:0]  fetch_length,
    output logic        fetch_su
);

    // Flat code segment, offset equals linear address
    logic [31:0] limit;
    // Set by the first branch after reset
    logic        active;
    // Bytes up to and including the limit byte
    logic [32:0] left;

    assign left = (!active || fetch_address > limit) ? 33'd0 :
                  {1'b0, limit} - {1'b0, fetch_address} + 33'd1;

    // Clip to one cache read, page clip is done by the control
    assign fetch_length = (left > 33'(`PF_MAX_LENGTH)) ? 6'(`PF_MAX_LENGTH) : left[5:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_address <= '0;
            limit         <= '0;
            fetch_su      <= 1'b0;
            active        <= 1'b0;
        end else if (branch) begin
            fetch_address <= branch_address;
            limit         <= cs_limit;
            fetch_su      <= su;
            active        <= 1'b1;
        end else if (advance) begin
            // Step by bytes delivered to the queue
            fetch_address <= fetch_address + 32'(advance_count);
        end
    end

    // Reader never delivers past the segment limit
    a_advance_in_limit: assert property (@(posedge clk) disable iff (!arst_n)
        advance && !branch |-> {30'd0, advance_count} <= left);

endmodule

//--- src/prefetch_if.sv
`timescale 1ns/1ps

// Translation request from control, answer from code TLB
interface tlb_code_if;
    logic        request_do;
    logic [31:0] request_address;
    // High for a user-mode fetch
    logic        request_su;

    logic        resp_do;
    logic [31:0] resp_linear;
    logic [31:0] resp_physical;
    logic        resp_cache_disable;

    modport requester (
        output request_do, request_address, request_su,
        input  resp_do, resp_linear, resp_physical, resp_cache_disable
    );

    modport translator (
        input  request_do, request_address, request_su,
        output resp_do, resp_linear, resp_physical, resp_cache_disable
    );
endinterface

// Cache read request, a level as a cache would see it
interface icache_read_if;
    logic        read_do;
    logic [31:0] read_address;
    logic [5:0]  read_length;
    logic        read_cache_disable;

    modport control (output read_do, read_address, read_length, read_cache_disable);
    modport reader  (input  read_do, read_address, read_length, read_cache_disable);
endinterface

//--- src/prefetch_pkg.sv
package prefetch_pkg;

    // One queue entry, byte 0 in the low bits
    typedef struct packed {
        logic [2:0]  count;
        logic [31:0] data;
    } code_word_t;

    // Code TLB entry
    typedef struct packed {
        logic        valid;
        logic [19:0] linear_page;
        logic [19:0] physical_page;
        // Page allowed for user-mode fetch
        logic        user;
        logic        cache_disable;
    } tlb_entry_t;

    // Control FSM
    typedef enum logic {
        TLB_REQUEST,
        ICACHE
    } pf_state_t;

    // Reader FSM
    typedef enum logic [1:0] {
        IDLE,
        READ,
        SETTLE
    } reader_state_t;

endpackage

//--- src/prefetch_defines.svh
`ifndef PREFETCH_DEFINES_SVH
`define PREFETCH_DEFINES_SVH

// Code queue entries
`define PF_FIFO_DEPTH   16

// Start a translation only below this fill level
`define PF_START_USED   2

// Leave the read state at or above this fill level
`define PF_STOP_USED    8

// Most bytes asked for by one cache read
`define PF_MAX_LENGTH   16

// Code TLB entries
`define PF_TLB_ENTRIES  8

`endif
